//--- design/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// entries in each of the tx and rx fifos
`define UART_FIFO_DEPTH 16

// bits per character, sent lsb first
`define UART_DATA_BITS 8

// shortest bit period the tx and rx state machines can handle
// (rx needs a non-zero half period to confirm the start bit)
`define UART_MIN_CLKS_PER_BIT 4

`endif

//--- design/uartPkg.sv
`default_nettype none

`include "uart_defs.svh"

package uartPkg;

    // run-time line configuration
    typedef struct packed {
        logic [15:0] clksPerBit;
        logic        parityEn;
    } uartCfg_t;

    // one received character plus its error flags
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
        logic                       parityErr;
        logic                       frameErr;
    } rxByte_t;

    typedef enum logic [2:0] {
        TxIdle, TxStart, TxData, TxParity, TxStop
    } txState_e;

    typedef enum logic [2:0] {
        RxIdle, RxStart, RxData, RxParity, RxStop
    } rxState_e;

endpackage

`default_nettype wire

//--- design/SyncFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module SyncFifo #(
    parameter type T_Payload = logic [`UART_DATA_BITS-1:0],
    parameter int  Depth     = `UART_FIFO_DEPTH
) (
    input  logic     i_Clk,
    input  logic     i_rst,
    input  logic     i_Write,
    input  T_Payload i_WrData,
    input  logic     i_Read,
    output T_Payload o_RdData,
    output logic     o_Full,
    output logic     o_Empty
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    T_Payload        mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic [CntW-1:0] countNext;
    logic            doWrite;
    logic            doRead;
    logic            full;
    logic            empty;

    // writes to a full fifo and reads from an empty one are ignored
    assign doWrite = i_Write && !full;
    assign doRead  = i_Read && !empty;

    always_comb begin
        case ({doWrite, doRead})
            2'b10:   countNext = count + CntW'(1);
            2'b01:   countNext = count - CntW'(1);
            default: countNext = count;
        endcase
    end

    always_ff @(posedge i_Clk) begin
        if (doWrite) begin
            mem[wrPtr] <= i_WrData;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + PtrW'(1);
            end
            if (doRead) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + PtrW'(1);
            end
            count <= countNext;
            // flags registered from the next count
            full  <= (countNext == CntW'(Depth));
            empty <= (countNext == '0);
        end
    end

    // head entry is valid whenever the fifo is not empty
    assign o_RdData = mem[rdPtr];
    assign o_Full   = full;
    assign o_Empty  = empty;

    countInRange: assert property (
        @(posedge i_Clk) disable iff (i_rst) count <= CntW'(Depth)
    ) else $error("fifo count %0d exceeds depth %0d", count, Depth);

endmodule

`default_nettype wire

//--- design/UartTx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module UartTx (
    input  logic                       i_Clk,
    input  logic                       i_rst,
    input  uartPkg::uartCfg_t          i_Cfg,
    input  logic                       i_Avail,
    input  logic [`UART_DATA_BITS-1:0] i_Data,
    output logic                       o_Pop,
    output logic                       o_Busy,
    output logic                       o_UartTx
);

    import uartPkg::*;

    localparam int IdxW = $clog2(`UART_DATA_BITS);

    txState_e                   state;
    logic [15:0]                cnt;
    logic [IdxW-1:0]            bitIdx;
    logic [`UART_DATA_BITS-1:0] shReg;
    logic                       parityBit;
    logic                       txLine;
    logic                       bitEnd;

    assign bitEnd = (cnt == i_Cfg.clksPerBit - 16'd1);

    // take the head byte only from idle
    assign o_Pop  = (state == TxIdle) && i_Avail;
    assign o_Busy = (state != TxIdle);

    ////////////////////////////////////////////////////////////
    // frame sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state  <= TxIdle;
            cnt    <= '0;
            bitIdx <= '0;
            txLine <= 1'b1;
        end else begin
            case (state)
                TxIdle: begin
                    cnt    <= '0;
                    bitIdx <= '0;
                    if (i_Avail) begin
                        state  <= TxStart;
                        txLine <= 1'b0;
                    end else begin
                        txLine <= 1'b1;
                    end
                end
                TxStart: begin
                    if (bitEnd) begin
                        cnt    <= '0;
                        state  <= TxData;
                        txLine <= shReg[0];
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                TxData: begin
                    if (bitEnd) begin
                        cnt <= '0;
                        if (bitIdx == IdxW'(`UART_DATA_BITS - 1)) begin
                            bitIdx <= '0;
                            if (i_Cfg.parityEn) begin
                                state  <= TxParity;
                                txLine <= parityBit;
                            end else begin
                                state  <= TxStop;
                                txLine <= 1'b1;
                            end
                        end else begin
                            bitIdx <= bitIdx + IdxW'(1);
                            txLine <= shReg[1];
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                TxParity: begin
                    if (bitEnd) begin
                        cnt    <= '0;
                        state  <= TxStop;
                        txLine <= 1'b1;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                TxStop: begin
                    txLine <= 1'b1;
                    if (bitEnd) begin
                        cnt   <= '0;
                        state <= TxIdle;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: state <= TxIdle;
            endcase
        end
    end

    // byte is held here so the fifo head can move on
    always_ff @(posedge i_Clk) begin
        if (o_Pop) begin
            shReg     <= i_Data;
            parityBit <= ^i_Data;
        end else if (state == TxData && bitEnd) begin
            shReg <= shReg >> 1;
        end
    end

    assign o_UartTx = txLine;

    bitPeriodLegal: assert property (
        @(posedge i_Clk) disable iff (i_rst)
        o_Busy |-> (i_Cfg.clksPerBit >= 16'(`UART_MIN_CLKS_PER_BIT))
    ) else $error("clksPerBit %0d below minimum while busy", i_Cfg.clksPerBit);

endmodule

`default_nettype wire

//--- design/UartRx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module UartRx (
    input  logic              i_Clk,
    input  logic              i_rst,
    input  uartPkg::uartCfg_t i_Cfg,
    input  logic              i_UartRx,
    output logic              o_Push,
    output uartPkg::rxByte_t  o_Byte
);

    import uartPkg::*;

    localparam int IdxW = $clog2(`UART_DATA_BITS);

    logic                       rxMeta;
    logic                       rxSync;
    logic                       rxPrev;
    logic                       rxFall;
    rxState_e                   state;
    logic [15:0]                cnt;
    logic [15:0]                halfEnd;
    logic                       bitEnd;
    logic [IdxW-1:0]            bitIdx;
    logic [`UART_DATA_BITS-1:0] shReg;
    logic                       parityErr;
    logic                       push;
    rxByte_t                    byteQ;

    ////////////////////////////////////////////////////////////
    // input synchronizer and start edge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= i_UartRx;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    assign rxFall  = rxPrev && !rxSync;
    assign halfEnd = (i_Cfg.clksPerBit >> 1) - 16'd1;
    assign bitEnd  = (cnt == i_Cfg.clksPerBit - 16'd1);

    ////////////////////////////////////////////////////////////
    // bit sampler
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state     <= RxIdle;
            cnt       <= '0;
            bitIdx    <= '0;
            parityErr <= 1'b0;
            push      <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                RxIdle: begin
                    cnt    <= '0;
                    bitIdx <= '0;
                    if (rxFall) begin
                        state <= RxStart;
                    end
                end
                RxStart: begin
                    if (cnt == halfEnd) begin
                        cnt       <= '0;
                        parityErr <= 1'b0;
                        // line back high at mid start bit means a glitch
                        state     <= rxSync ? RxIdle : RxData;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                RxData: begin
                    if (bitEnd) begin
                        cnt <= '0;
                        if (bitIdx == IdxW'(`UART_DATA_BITS - 1)) begin
                            bitIdx <= '0;
                            state  <= i_Cfg.parityEn ? RxParity : RxStop;
                        end else begin
                            bitIdx <= bitIdx + IdxW'(1);
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                RxParity: begin
                    if (bitEnd) begin
                        cnt       <= '0;
                        // even parity over data and parity bit
                        parityErr <= rxSync ^ (^shReg);
                        state     <= RxStop;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                RxStop: begin
                    if (bitEnd) begin
                        cnt   <= '0;
                        push  <= 1'b1;
                        state <= RxIdle;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: state <= RxIdle;
            endcase
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge i_Clk) begin
        if (state == RxData && bitEnd) begin
            shReg <= {rxSync, shReg[`UART_DATA_BITS-1:1]};
        end
        if (state == RxStop && bitEnd) begin
            byteQ.data      <= shReg;
            byteQ.parityErr <= parityErr;
            byteQ.frameErr  <= !rxSync;
        end
    end

    assign o_Push = push;
    assign o_Byte = byteQ;

    singlePush: assert property (
        @(posedge i_Clk) disable iff (i_rst) o_Push |=> !o_Push
    ) else $error("rx push held for more than one cycle");

endmodule

`default_nettype wire

//--- design/UartCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module UartCore (
    input  logic                       i_Clk,
    input  logic                       i_rst,
    input  uartPkg::uartCfg_t          i_Cfg,
    input  logic                       i_TxWrite,
    input  logic [`UART_DATA_BITS-1:0] i_TxData,
    output logic                       o_TxFull,
    output logic                       o_Busy,
    output logic                       o_UartTx,
    input  logic                       i_UartRx,
    input  logic                       i_RxRead,
    output logic                       o_RxEmpty,
    output uartPkg::rxByte_t           o_RxByte,
    output logic                       o_RxOverflow
);

    import uartPkg::*;

    logic [`UART_DATA_BITS-1:0] txHead;
    logic                       txEmpty;
    logic                       txPop;
    logic                       rxPush;
    rxByte_t                    rxPushByte;
    logic                       rxFull;
    logic                       rxOverflow;

    ////////////////////////////////////////////////////////////
    // transmit path
    ////////////////////////////////////////////////////////////

    SyncFifo #(
        .T_Payload (logic [`UART_DATA_BITS-1:0])
    ) TxFifo_inst (
        .i_Clk    (i_Clk),
        .i_rst    (i_rst),
        .i_Write  (i_TxWrite),
        .i_WrData (i_TxData),
        .i_Read   (txPop),
        .o_RdData (txHead),
        .o_Full   (o_TxFull),
        .o_Empty  (txEmpty)
    );

    UartTx UartTx_inst (
        .i_Clk    (i_Clk),
        .i_rst    (i_rst),
        .i_Cfg    (i_Cfg),
        .i_Avail  (!txEmpty),
        .i_Data   (txHead),
        .o_Pop    (txPop),
        .o_Busy   (o_Busy),
        .o_UartTx (o_UartTx)
    );

    ////////////////////////////////////////////////////////////
    // receive path
    ////////////////////////////////////////////////////////////

    UartRx UartRx_inst (
        .i_Clk    (i_Clk),
        .i_rst    (i_rst),
        .i_Cfg    (i_Cfg),
        .i_UartRx (i_UartRx),
        .o_Push   (rxPush),
        .o_Byte   (rxPushByte)
    );

    SyncFifo #(
        .T_Payload (rxByte_t)
    ) RxFifo_inst (
        .i_Clk    (i_Clk),
        .i_rst    (i_rst),
        .i_Write  (rxPush),
        .i_WrData (rxPushByte),
        .i_Read   (i_RxRead),
        .o_RdData (o_RxByte),
        .o_Full   (rxFull),
        .o_Empty  (o_RxEmpty)
    );

    // sticky until reset once a received byte is lost
    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            rxOverflow <= 1'b0;
        end else if (rxPush && rxFull) begin
            rxOverflow <= 1'b1;
        end
    end

    assign o_RxOverflow = rxOverflow;

endmodule

`default_nettype wire

//--- sim/UartCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module UartCore_tb;

    import uartPkg::*;

    localparam int ClkPeriodNs   = 4;
    localparam int MaxClksPerBit = 8;
    // 12 + 12 + 1 + 4 + 17 + 17 frames over the six tests
    localparam int TotalFrames   = 63;
    localparam int WatchdogNs    = TotalFrames * 11 * MaxClksPerBit * ClkPeriodNs * 2 + 4000;

    logic                       i_Clk;
    logic                       i_rst;
    uartCfg_t                   cfg;
    logic                       txWrite;
    logic [`UART_DATA_BITS-1:0] txData;
    logic                       txFull;
    logic                       busy;
    logic                       serialTx;
    logic                       rxLine;
    logic                       rxRead;
    logic                       rxEmpty;
    rxByte_t                    rxByte;
    logic                       rxOverflow;

    logic        bangEn;
    logic        bangLine;
    logic [31:0] lfsrState;
    rxByte_t     expQ [$];
    int          errCount;
    int          idleErrs;
    int          resetErrs;
    int          stickyErrs;
    int          testNum;
    int          testErrBase;
    int          passCount;
    int          failCount;
    string       testName;

    UartCore UartCore_inst (
        .i_Clk        (i_Clk),
        .i_rst        (i_rst),
        .i_Cfg        (cfg),
        .i_TxWrite    (txWrite),
        .i_TxData     (txData),
        .o_TxFull     (txFull),
        .o_Busy       (busy),
        .o_UartTx     (serialTx),
        .i_UartRx     (rxLine),
        .i_RxRead     (rxRead),
        .o_RxEmpty    (rxEmpty),
        .o_RxByte     (rxByte),
        .o_RxOverflow (rxOverflow)
    );

    // loopback unless the bit-banged driver owns the line
    assign rxLine = bangEn ? bangLine : serialTx;

    initial begin
        i_Clk = 1'b0;
        forever #(ClkPeriodNs / 2) i_Clk = ~i_Clk;
    end

    initial begin
        #(WatchdogNs);
        $display("watchdog expired at %0d ns before the tests completed", $time);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////////////////////////

    lineIdleHigh: assert property (@(posedge i_Clk) disable iff (i_rst) !busy |-> serialTx)
    else begin
        idleErrs++;
        $display("Mismatch at %0d ns: tx line low while the transmitter is idle", $time);
    end

    // outputs on the first cycle out of reset
    resetValues: assert property (
        @(posedge i_Clk) $fell(i_rst) |->
            serialTx && !busy && !txFull && rxEmpty && !rxOverflow
    ) else begin
        resetErrs++;
        $display("Mismatch at %0d ns: outputs not at their reset values", $time);
    end

    overflowSticky: assert property (
        @(posedge i_Clk) disable iff (i_rst) rxOverflow |=> rxOverflow
    ) else begin
        stickyErrs++;
        $display("Mismatch at %0d ns: rx overflow flag cleared without reset", $time);
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic nextRandBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic logic [`UART_DATA_BITS-1:0] randByte();
        logic [`UART_DATA_BITS-1:0] b;
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            b[i] = nextRandBit();
        end
        return b;
    endfunction

    // bit that makes the count of ones even
    function automatic logic evenParity(input logic [`UART_DATA_BITS-1:0] d);
        logic p;
        p = 1'b0;
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            p = p ^ d[i];
        end
        return p;
    endfunction

    function automatic rxByte_t expectedEntry(
        input logic [`UART_DATA_BITS-1:0] d,
        input logic                       pe,
        input logic                       fe
    );
        rxByte_t r;
        r.data      = d;
        r.parityErr = pe;
        r.frameErr  = fe;
        return r;
    endfunction

    function automatic int totalErrors();
        return errCount + idleErrs + resetErrs + stickyErrs;
    endfunction

    task automatic tick();
        @(posedge i_Clk);
        #1;
    endtask

    task automatic setConfig(input logic [15:0] clks, input logic parity);
        cfg.clksPerBit = clks;
        cfg.parityEn   = parity;
        tick();
    endtask

    // first keep bytes are expected back, the rest are meant to be lost
    task automatic writeBurst(input int count, input int keep);
        logic [`UART_DATA_BITS-1:0] d;
        for (int i = 0; i < count; i++) begin
            d = randByte();
            if (i < keep) begin
                expQ.push_back(expectedEntry(d, 1'b0, 1'b0));
            end
            txData  = d;
            txWrite = 1'b1;
            tick();
        end
        txWrite = 1'b0;
    endtask

    task automatic waitBusy();
        int waited;
        waited = 0;
        while (!busy && waited < 8) begin
            tick();
            waited++;
        end
        assert (busy) else begin
            errCount++;
            $display("transmitter did not start within %0d cycles of a write", waited);
        end
    endtask

    task automatic waitTxIdle();
        int waited;
        waited = 0;
        while (busy && waited < 12 * int'(cfg.clksPerBit)) begin
            tick();
            waited++;
        end
        assert (!busy) else begin
            errCount++;
            $display("transmitter still busy at %0d ns", $time);
        end
        tick();
        tick();
    endtask

    task automatic receiveCheck();
        int      waited;
        rxByte_t got;
        rxByte_t exp;
        waited = 0;
        while (rxEmpty && waited < 22 * int'(cfg.clksPerBit) + 20) begin
            tick();
            waited++;
        end
        assert (!rxEmpty) else begin
            errCount++;
            $display("no byte received within %0d cycles, at %0d ns", waited, $time);
        end
        if (rxEmpty) begin
            return;
        end
        got = rxByte;
        assert (expQ.size() > 0) else begin
            errCount++;
            $display("received byte %02h that was never sent, at %0d ns", got.data, $time);
        end
        if (expQ.size() > 0) begin
            exp = expQ.pop_front();
            assert (got == exp) else begin
                errCount++;
                $display("Mismatch at %0d ns: expected %02h pe %0b fe %0b, got %02h pe %0b fe %0b",
                         $time, exp.data, exp.parityErr, exp.frameErr,
                         got.data, got.parityErr, got.frameErr);
            end
        end
        rxRead = 1'b1;
        tick();
        rxRead = 1'b0;
    endtask

    // one frame with exact bit periods on the serial input
    task automatic sendFrame(
        input logic [`UART_DATA_BITS-1:0] d,
        input logic                       parityBit,
        input logic                       stopBit
    );
        int n;
        n = int'(cfg.clksPerBit);
        bangLine = 1'b0;
        repeat (n) tick();
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            bangLine = d[i];
            repeat (n) tick();
        end
        if (cfg.parityEn) begin
            bangLine = parityBit;
            repeat (n) tick();
        end
        bangLine = stopBit;
        repeat (n) tick();
        bangLine = 1'b1;
        repeat (2 * n) tick();
    endtask

    task automatic startTest(input string name);
        testNum++;
        testName    = name;
        testErrBase = totalErrors();
    endtask

    task automatic finishTest();
        int errs;
        assert (expQ.size() == 0) else begin
            errCount++;
            $display("%0d expected bytes never arrived", expQ.size());
        end
        expQ.delete();
        errs = totalErrors() - testErrBase;
        if (errs == 0) begin
            passCount++;
            $display("[%0d] %s: ok", testNum, testName);
        end else begin
            failCount++;
            $display("[%0d] %s: FAIL with %0d errors", testNum, testName, errs);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [`UART_DATA_BITS-1:0] d;
        logic                       lowRun;
        logic                       badParity;
        logic                       stopBit;
        int                         lowCycles;
        int                         busyCycles;
        int                         waited;

        i_rst          = 1'b1;
        cfg.clksPerBit = 16'd8;
        cfg.parityEn   = 1'b0;
        txWrite        = 1'b0;
        txData         = '0;
        rxRead         = 1'b0;
        bangEn         = 1'b0;
        bangLine       = 1'b1;
        lfsrState      = 32'h7157_9e07;
        errCount       = 0;
        idleErrs       = 0;
        resetErrs      = 0;
        stickyErrs     = 0;
        testNum        = 0;
        passCount      = 0;
        failCount      = 0;
        repeat (16) tick();
        i_rst = 1'b0;
        tick();

        startTest("loopback without parity");
        setConfig(16'd8, 1'b0);
        writeBurst(12, 12);
        repeat (12) receiveCheck();
        waitTxIdle();
        finishTest();

        startTest("loopback with parity");
        setConfig(16'd5, 1'b1);
        writeBurst(12, 12);
        repeat (12) receiveCheck();
        waitTxIdle();
        finishTest();

        // lsb forced high so the start bit ends where data bit 0 begins
        startTest("line idle and frame length");
        setConfig(16'd8, 1'b0);
        d = randByte() | 8'h01;
        expQ.push_back(expectedEntry(d, 1'b0, 1'b0));
        txData  = d;
        txWrite = 1'b1;
        tick();
        txWrite = 1'b0;
        waitBusy();
        lowCycles  = 0;
        busyCycles = 0;
        lowRun     = 1'b1;
        while (busy && busyCycles < 20 * MaxClksPerBit) begin
            busyCycles++;
            if (lowRun && !serialTx) begin
                lowCycles++;
            end else begin
                lowRun = 1'b0;
            end
            tick();
        end
        assert (lowCycles == int'(cfg.clksPerBit)) else begin
            errCount++;
            $display("Mismatch at %0d ns: start bit lasted %0d cycles, expected %0d",
                     $time, lowCycles, cfg.clksPerBit);
        end
        assert (busyCycles == 10 * int'(cfg.clksPerBit)) else begin
            errCount++;
            $display("Mismatch at %0d ns: frame lasted %0d cycles, expected %0d",
                     $time, busyCycles, 10 * int'(cfg.clksPerBit));
        end
        receiveCheck();
        finishTest();

        startTest("parity and stop bit errors");
        setConfig(16'd8, 1'b1);
        bangEn = 1'b1;
        for (int f = 0; f < 4; f++) begin
            d = randByte();
            case (f)
                0:       badParity = 1'b1;
                1:       badParity = 1'b0;
                default: badParity = nextRandBit();
            endcase
            stopBit = (f != 1);
            expQ.push_back(expectedEntry(d, badParity, !stopBit));
            sendFrame(d, evenParity(d) ^ badParity, stopBit);
            receiveCheck();
        end
        bangEn = 1'b0;
        tick();
        finishTest();

        startTest("tx fifo full and dropped write");
        setConfig(16'd4, 1'b0);
        d = randByte();
        expQ.push_back(expectedEntry(d, 1'b0, 1'b0));
        txData  = d;
        txWrite = 1'b1;
        tick();
        txWrite = 1'b0;
        waitBusy();
        // first frame is on the line, so sixteen more fill the fifo
        for (int i = 0; i < 17; i++) begin
            d = randByte();
            if (i < 16) begin
                assert (!txFull) else begin
                    errCount++;
                    $display("Mismatch at %0d ns: tx fifo full after %0d writes", $time, i);
                end
                expQ.push_back(expectedEntry(d, 1'b0, 1'b0));
            end else begin
                assert (txFull) else begin
                    errCount++;
                    $display("Mismatch at %0d ns: tx fifo not full after 16 writes", $time);
                end
            end
            txData  = d;
            txWrite = 1'b1;
            tick();
        end
        txWrite = 1'b0;
        repeat (17) receiveCheck();
        repeat (12 * int'(cfg.clksPerBit)) tick();
        assert (rxEmpty && !busy) else begin
            errCount++;
            $display("Mismatch at %0d ns: a frame was sent for the dropped write", $time);
        end
        finishTest();

        startTest("rx fifo overflow");
        setConfig(16'd4, 1'b0);
        assert (!rxOverflow) else begin
            errCount++;
            $display("Mismatch at %0d ns: rx overflow set before the test", $time);
        end
        writeBurst(17, 16);
        waited = 0;
        while (!rxOverflow && waited < 17 * 22 * int'(cfg.clksPerBit)) begin
            tick();
            waited++;
        end
        assert (rxOverflow) else begin
            errCount++;
            $display("rx overflow never reported after 17 frames, at %0d ns", $time);
        end
        waitTxIdle();
        repeat (16) receiveCheck();
        assert (rxEmpty && rxOverflow) else begin
            errCount++;
            $display("Mismatch at %0d ns: empty %0b overflow %0b after draining",
                     $time, rxEmpty, rxOverflow);
        end
        finishTest();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 testNum, passCount, failCount, totalErrors());
        if (failCount == 0 && totalErrors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- UartCore.f
+incdir+design
design/uartPkg.sv
design/SyncFifo.sv
design/UartTx.sv
design/UartRx.sv
design/UartCore.sv
sim/UartCore_tb.sv

//--- Makefile
# Verilator build and run for the UART core testbench

TOP := UartCore_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): UartCore.f design/*.sv design/*.svh sim/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f UartCore.f -o $(TOP)

# the log is searched for the fail message, a crashed run also counts as failure
run: compile
	@./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then \
		echo "simulation reported failure, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
